/* rtl/cpuPkg.sv */
// shared sizes, opcode and ALU encodings, and the control and retirement records of the cpu.
package cpuPkg;

	// **************************************************************************
	// sizes
	// **************************************************************************
	localparam int pcWidth = 6;
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int dmemAddrWidth = 8;
	localparam int imemDepth = 64;
	localparam string programFile = "verification/program.hex";

	// **************************************************************************
	// encodings
	// **************************************************************************
	typedef enum logic [5:0] {
		opRtype = 6'd0,
		opBeq = 6'd4,
		opBne = 6'd5,
		opAddi = 6'd8,
		opLw = 6'd35,
		opSw = 6'd43,
		opHlt = 6'd63
	} opcodeT;

	typedef enum logic [5:0] {
		fnAdd = 6'd32,
		fnSub = 6'd34,
		fnAnd = 6'd36,
		fnOr = 6'd37,
		fnSlt = 6'd42
	} functT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluOpT;

	// decoder output, 13 bits.
	typedef struct packed {
		logic spare; // always zero.
		logic regDst;
		logic aluSrc;
		aluOpT aluOp;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic regWrite;
		logic branch;
		logic branchNe;
		logic halt;
	} controlT;

	// one record per executed instruction.
	typedef struct packed {
		logic valid;
		logic [pcWidth-1:0] pc;
		logic regWrite;
		logic [regAddrWidth-1:0] writeReg;
		logic [dataWidth-1:0] writeData;
		logic memWrite;
		logic [dmemAddrWidth-1:0] memAddr;
		logic halt;
	} retireT;

endpackage

/* rtl/fetchUnit.sv */
// program counter, instruction ROM and next-PC selection, frozen for good by a hlt.
`timescale 1ns/1ps

module fetchUnit import cpuPkg::*; (
	input logic clk,
	input logic rst,
	input logic branchTaken,
	input logic [5:0] imm6,
	input logic halt,
	output logic [pcWidth-1:0] pc,
	output logic [dataWidth-1:0] instruction,
	output logic halted
);

	logic [dataWidth-1:0] rom [imemDepth];
	logic [pcWidth-1:0] pcPlus1;
	logic [pcWidth-1:0] branchTarget;
	logic [pcWidth-1:0] nextPc;

	// program image.
	initial begin
		$readmemh(programFile, rom);
	end

	assign instruction = rom[pc];

	// both sums wrap at 64.
	assign pcPlus1 = pc + pcWidth'(1);
	assign branchTarget = pc + imm6;
	assign nextPc = branchTaken ? branchTarget : pcPlus1;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pc <= '0;
			halted <= 1'b0;
		end else if (!halted) begin
			if (halt) begin
				halted <= 1'b1; // pc stays on the hlt.
			end else begin
				pc <= nextPc;
			end
		end
	end

	// ************************************************************************
	// checks
	// ************************************************************************
	// once halted, the PC never moves again until reset.
	pcFrozen: assert property (@(posedge clk) disable iff (!rst)
		halted |=> ($stable(pc) && halted));

endmodule

/* rtl/instructionDecoder.sv */
// splits an instruction into its fields and decodes the opcode and funct into control.
`timescale 1ns/1ps

module instructionDecoder import cpuPkg::*; (
	input logic [dataWidth-1:0] instruction,
	output logic [regAddrWidth-1:0] rs,
	output logic [regAddrWidth-1:0] rt,
	output logic [regAddrWidth-1:0] writeReg,
	output logic [dataWidth-1:0] immExt,
	output logic [5:0] imm6,
	output controlT ctrl
);

	opcodeT opcode;
	functT funct;
	logic [regAddrWidth-1:0] rd;
	logic [15:0] imm;
	logic rLegal;
	aluOpT rOp;

	assign opcode = opcodeT'(instruction[31:26]);
	assign rs = instruction[25:21];
	assign rt = instruction[20:16];
	assign rd = instruction[15:11];
	assign funct = functT'(instruction[5:0]);
	assign imm = instruction[15:0];

	assign immExt = {{(dataWidth-16){imm[15]}}, imm};
	assign imm6 = imm[5:0]; // branch offset.

	// R-type ALU operation.
	always_comb begin
		rLegal = 1'b1;
		rOp = aluAdd;
		case (funct)
			fnAdd: rOp = aluAdd;
			fnSub: rOp = aluSub;
			fnAnd: rOp = aluAnd;
			fnOr: rOp = aluOr;
			fnSlt: rOp = aluSlt;
			default: rLegal = 1'b0;
		endcase
	end

	// unknown encodings fall through as all zero, a no-op.
	always_comb begin
		ctrl = '0;
		case (opcode)
			opRtype: begin
				ctrl.regDst = rLegal;
				ctrl.regWrite = rLegal;
				ctrl.aluOp = rOp;
			end
			opAddi: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opLw: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opSw: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			opBeq: begin
				ctrl.branch = 1'b1;
				ctrl.aluOp = aluSub;
			end
			opBne: begin
				ctrl.branch = 1'b1;
				ctrl.branchNe = 1'b1;
				ctrl.aluOp = aluSub;
			end
			opHlt: ctrl.halt = 1'b1;
			default: ctrl = '0;
		endcase
	end

	assign writeReg = ctrl.regDst ? rd : rt; // rd for R-type.

	// a load and a store together would corrupt the write-back path.
	always_comb begin
		noLoadStore: assert final (!(ctrl.memRead && ctrl.memWrite));
	end

endmodule

/* rtl/registerFile.sv */
// 32 x 32 register file, two asynchronous reads and one clocked write, register 0 fixed at zero.
`timescale 1ns/1ps

module registerFile import cpuPkg::*; (
	input logic clk,
	input logic rst,
	input logic [regAddrWidth-1:0] readReg1,
	input logic [regAddrWidth-1:0] readReg2,
	input logic [regAddrWidth-1:0] writeReg,
	input logic writeEn,
	input logic [dataWidth-1:0] writeData,
	output logic [dataWidth-1:0] readData1,
	output logic [dataWidth-1:0] readData2
);

	localparam int regCount = 2 ** regAddrWidth;

	logic [dataWidth-1:0] regs [regCount];
	logic writeOk;

	// register 0 never takes a write.
	assign writeOk = writeEn && (writeWriteRegNonZero(writeReg));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeOk) begin
			regs[writeReg] <= writeData;
		end
	end

	// reads see the old value until the edge.
	assign readData1 = (readReg1 == '0) ? '0 : regs[readReg1];
	assign readData2 = (readReg2 == '0) ? '0 : regs[readReg2];

	function automatic logic writeWriteRegNonZero(input logic [regAddrWidth-1:0] addr);
		return addr != '0;
	endfunction

endmodule

/* rtl/executeUnit.sv */
// ALU with operand selection, zero flag and the branch decision.
`timescale 1ns/1ps

module executeUnit import cpuPkg::*; (
	input logic [dataWidth-1:0] readData1,
	input logic [dataWidth-1:0] readData2,
	input logic [dataWidth-1:0] immExt,
	input controlT ctrl,
	output logic [dataWidth-1:0] aluResult,
	output logic branchTaken
);

	logic [dataWidth-1:0] operandB;
	logic [dataWidth-1:0] difference;
	logic lessThan;
	logic zero;

	// ************************************************************************
	// operands
	// ************************************************************************
	assign operandB = ctrl.aluSrc ? immExt : readData2;

	// shared by sub, slt and the branch compare.
	assign difference = readData1 - operandB;
	assign lessThan = $signed(readData1) < $signed(operandB);
	assign zero = (difference == '0);

	// ************************************************************************
	// ALU
	// ************************************************************************
	always_comb begin
		case (ctrl.aluOp)
			aluAdd: aluResult = readData1 + operandB;
			aluSub: aluResult = difference;
			aluAnd: aluResult = readData1 & operandB;
			aluOr: aluResult = readData1 | operandB;
			aluSlt: aluResult = {{(dataWidth-1){1'b0}}, lessThan};
			default: aluResult = '0;
		endcase
	end

	// beq on zero, bne on non-zero.
	always_comb begin
		if (!ctrl.branch) begin
			branchTaken = 1'b0;
		end else if (ctrl.branchNe) begin
			branchTaken = !zero;
		end else begin
			branchTaken = zero;
		end
	end

endmodule

/* rtl/memoryWriteback.sv */
// data memory, write-back selection and the per-instruction retirement record.
`timescale 1ns/1ps

module memoryWriteback import cpuPkg::*; (
	input logic clk,
	input logic rst,
	input logic [pcWidth-1:0] pc,
	input logic [dataWidth-1:0] aluResult,
	input logic [dataWidth-1:0] storeData,
	input logic [regAddrWidth-1:0] writeReg,
	input controlT ctrl,
	input logic halted,
	output logic [dataWidth-1:0] writeData,
	output logic regWrite,
	output retireT retire
);

	localparam int dmemDepth = 2 ** dmemAddrWidth;

	logic [dataWidth-1:0] dmem [dmemDepth];
	logic [dmemAddrWidth-1:0] memAddr;
	logic [dataWidth-1:0] loadData;
	logic memWrite;
	logic executing;

	assign executing = rst && !halted; // no instruction runs in reset or after hlt.
	assign memAddr = aluResult[dmemAddrWidth-1:0];
	assign memWrite = ctrl.memWrite && !halted;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < dmemDepth; i++) begin
				dmem[i] <= '0;
			end
		end else if (memWrite) begin
			dmem[memAddr] <= storeData;
		end
	end

	assign loadData = ctrl.memRead ? dmem[memAddr] : '0;
	assign writeData = ctrl.memToReg ? loadData : aluResult;
	assign regWrite = ctrl.regWrite && !halted;

	// ************************************************************************
	// retirement
	// ************************************************************************
	always_comb begin
		retire.valid = executing;
		retire.pc = pc;
		retire.regWrite = regWrite;
		retire.writeReg = writeReg;
		retire.writeData = writeData;
		retire.memWrite = memWrite;
		retire.memAddr = memAddr;
		retire.halt = ctrl.halt;
	end

endmodule

/* rtl/processor.sv */
// top level of the single-cycle cpu, runs the program ROM to hlt and reports every retirement.
`timescale 1ns/1ps

module processor import cpuPkg::*; (
	input logic clk,
	input logic rst,
	output logic [pcWidth-1:0] pc,
	output logic halted,
	output logic [31:0] cyclesConsumed,
	output retireT retire
);

	logic [dataWidth-1:0] instruction;
	logic [regAddrWidth-1:0] rs;
	logic [regAddrWidth-1:0] rt;
	logic [regAddrWidth-1:0] writeReg;
	logic [dataWidth-1:0] immExt;
	logic [5:0] imm6;
	controlT ctrl;
	logic [dataWidth-1:0] readData1;
	logic [dataWidth-1:0] readData2;
	logic [dataWidth-1:0] aluResult;
	logic branchTaken;
	logic [dataWidth-1:0] writeData;
	logic regWrite;

	fetchUnit i_fetch (.clk(clk), .rst(rst), .branchTaken(branchTaken), .imm6(imm6),
		.halt(ctrl.halt), .pc(pc), .instruction(instruction), .halted(halted));

	instructionDecoder i_decoder (.instruction(instruction), .rs(rs), .rt(rt),
		.writeReg(writeReg), .immExt(immExt), .imm6(imm6), .ctrl(ctrl));

	registerFile i_regs (.clk(clk), .rst(rst), .readReg1(rs), .readReg2(rt),
		.writeReg(writeReg), .writeEn(regWrite), .writeData(writeData),
		.readData1(readData1), .readData2(readData2));

	executeUnit i_execute (.readData1(readData1), .readData2(readData2), .immExt(immExt),
		.ctrl(ctrl), .aluResult(aluResult), .branchTaken(branchTaken));

	memoryWriteback i_memWb (.clk(clk), .rst(rst), .pc(pc), .aluResult(aluResult),
		.storeData(readData2), .writeReg(writeReg), .ctrl(ctrl), .halted(halted),
		.writeData(writeData), .regWrite(regWrite), .retire(retire));

	// one count per retired instruction.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cyclesConsumed <= '0;
		end else if (retire.valid) begin
			cyclesConsumed <= cyclesConsumed + 32'd1;
		end
	end

	// the counter freezes together with fetch.
	countFrozen: assert property (@(posedge clk) disable iff (!rst)
		halted |=> $stable(cyclesConsumed));

endmodule

/* verification/isaRefModel.sv */
// instruction-set model of the cpu, steps one instruction per clock next to the DUT and predicts each retirement.
`timescale 1ns/1ps

module isaRefModel import cpuPkg::*; (
	input logic clk,
	input logic rst,
	output retireT expRetire,
	output logic [pcWidth-1:0] expPc,
	output logic expHalted,
	output logic [31:0] expCount
);

	logic [31:0] image [imemDepth];
	logic [31:0] regs [32];
	logic [31:0] mem [256];
	logic [31:0] inst;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [31:0] imm;
	logic [31:0] effAddr;
	logic [pcWidth-1:0] nextPc;

	initial begin
		$readmemh(programFile, image);
	end

	assign inst = image[expPc];
	assign opA = (inst[25:21] == 5'd0) ? 32'd0 : regs[inst[25:21]]; // r0 reads zero.
	assign opB = (inst[20:16] == 5'd0) ? 32'd0 : regs[inst[20:16]];
	assign imm = {{16{inst[15]}}, inst[15:0]};
	assign effAddr = opA + imm;

	// ************************************************************************
	// prediction for the instruction at expPc
	// ************************************************************************
	always_comb begin
		expRetire = '0;
		expRetire.valid = rst && !expHalted;
		expRetire.pc = expPc;
		nextPc = expPc + 6'd1;
		case (inst[31:26])
			6'd0: begin
				expRetire.regWrite = 1'b1;
				expRetire.writeReg = inst[15:11];
				case (inst[5:0])
					6'd32: expRetire.writeData = opA + opB;
					6'd34: expRetire.writeData = opA - opB;
					6'd36: expRetire.writeData = opA & opB;
					6'd37: expRetire.writeData = opA | opB;
					6'd42: expRetire.writeData = {31'd0, $signed(opA) < $signed(opB)};
					default: expRetire.regWrite = 1'b0; // unknown funct, no-op.
				endcase
			end
			6'd8: begin
				expRetire.regWrite = 1'b1;
				expRetire.writeReg = inst[20:16];
				expRetire.writeData = effAddr; // addi.
			end
			6'd35: begin
				expRetire.regWrite = 1'b1;
				expRetire.writeReg = inst[20:16];
				expRetire.writeData = mem[effAddr[7:0]];
			end
			6'd43: begin
				expRetire.memWrite = 1'b1;
				expRetire.memAddr = effAddr[7:0];
			end
			6'd4: if (opA == opB) nextPc = expPc + inst[5:0];
			6'd5: if (opA != opB) nextPc = expPc + inst[5:0];
			6'd63: expRetire.halt = 1'b1;
			default: ; // unknown opcode.
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			expPc <= '0;
			expHalted <= 1'b0;
			expCount <= '0;
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
			for (int i = 0; i < 256; i++) begin
				mem[i] <= '0;
			end
		end else if (!expHalted) begin
			expCount <= expCount + 32'd1; // hlt counts too.
			if (expRetire.halt) begin
				expHalted <= 1'b1;
			end else begin
				expPc <= nextPc;
			end
			if (expRetire.regWrite && expRetire.writeReg != 5'd0) begin
				regs[expRetire.writeReg] <= expRetire.writeData;
			end
			if (expRetire.memWrite) begin
				mem[expRetire.memAddr] <= opB;
			end
		end
	end

endmodule

/* verification/processorTb.sv */
// testbench for the cpu, runs the program image beside the ISA model and checks the DUT every cycle.
`timescale 1ns/1ps

module processorTb import cpuPkg::*; ();

	// 3 reset cycles, 32 retirements, the halt hold, plus margin.
	localparam int maxCycles = 200;
	localparam int holdCycles = 5;

	logic clk;
	logic rst;
	logic [pcWidth-1:0] pc;
	logic halted;
	logic [31:0] cyclesConsumed;
	retireT retire;
	retireT expRetire;
	logic [pcWidth-1:0] expPc;
	logic expHalted;
	logic [31:0] expCount;
	logic timedOut;
	int errors = 0;
	int checks = 0;
	int cycleCount = 0;

	processor i_dut (.clk(clk), .rst(rst), .pc(pc), .halted(halted),
		.cyclesConsumed(cyclesConsumed), .retire(retire));

	isaRefModel i_ref (.clk(clk), .rst(rst), .expRetire(expRetire), .expPc(expPc),
		.expHalted(expHalted), .expCount(expCount));

	always #4 clk = ~clk;

	always @(posedge clk) cycleCount <= cycleCount + 1;

	task automatic reportMismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		errors++;
		$display("FAILED %s expected %0h actual %0h", name, expected, actual);
	endtask

	// ************************************************************************
	// checks
	// ************************************************************************
	resetState: assert property (@(posedge clk)
		rst || (pc == '0 && !halted && cyclesConsumed == '0 && !retire.valid)) checks++;
	else reportMismatch("resetState", 64'd0, 64'({$sampled(pc), $sampled(halted),
		$sampled(cyclesConsumed), $sampled(retire.valid)}));

	afterReset: assert property (@(posedge clk)
		!(rst && !$past(rst)) || (pc == '0 && !halted && cyclesConsumed == '0)) checks++;
	else reportMismatch("afterReset", 64'd0,
		64'({$sampled(pc), $sampled(halted), $sampled(cyclesConsumed)}));

	validMatch: assert property (@(posedge clk) disable iff (!rst)
		retire.valid == expRetire.valid) checks++;
	else reportMismatch("validMatch", 64'($sampled(expRetire.valid)),
		64'($sampled(retire.valid)));

	pcMatch: assert property (@(posedge clk) disable iff (!rst) pc == expPc) checks++;
	else reportMismatch("pcMatch", 64'($sampled(expPc)), 64'($sampled(pc)));

	haltedMatch: assert property (@(posedge clk) disable iff (!rst)
		halted == expHalted) checks++;
	else reportMismatch("haltedMatch", 64'($sampled(expHalted)), 64'($sampled(halted)));

	countMatch: assert property (@(posedge clk) disable iff (!rst)
		cyclesConsumed == expCount) checks++;
	else reportMismatch("countMatch", 64'($sampled(expCount)),
		64'($sampled(cyclesConsumed)));

	retireMatch: assert property (@(posedge clk) disable iff (!rst)
		!expRetire.valid || (retire.pc == expRetire.pc
		&& retire.regWrite == expRetire.regWrite && retire.memWrite == expRetire.memWrite
		&& retire.halt == expRetire.halt)) checks++;
	else reportMismatch("retireMatch", 64'($sampled(expRetire)), 64'($sampled(retire)));

	// write fields only mean something when regWrite is set.
	writeMatch: assert property (@(posedge clk) disable iff (!rst)
		!(expRetire.valid && expRetire.regWrite) || (retire.writeReg == expRetire.writeReg
		&& retire.writeData == expRetire.writeData)) checks++;
	else reportMismatch("writeMatch",
		64'({$sampled(expRetire.writeReg), $sampled(expRetire.writeData)}),
		64'({$sampled(retire.writeReg), $sampled(retire.writeData)}));

	storeMatch: assert property (@(posedge clk) disable iff (!rst)
		!(expRetire.valid && expRetire.memWrite)
		|| retire.memAddr == expRetire.memAddr) checks++;
	else reportMismatch("storeMatch", 64'($sampled(expRetire.memAddr)),
		64'($sampled(retire.memAddr)));

	haltHold: assert property (@(posedge clk) disable iff (!rst)
		!$past(halted) || (halted && !retire.valid && $stable(pc))) checks++;
	else begin
		errors++;
		$display("halt not held: halted dropped, a retirement showed up or pc moved");
	end

	// ************************************************************************
	// stimulus and report
	// ************************************************************************
	initial begin
		clk = 1'b0;
		rst = 1'b0;
		timedOut = 1'b0;
		repeat (3) @(posedge clk);
		#1 rst = 1'b1;
		while (!halted && cycleCount < maxCycles) begin
			@(posedge clk);
			#1;
		end
		if (!halted) begin
			timedOut = 1'b1;
			$display("timeout: the program did not reach hlt within %0d cycles", maxCycles);
		end else begin
			repeat (holdCycles) @(posedge clk); // let the halt checks run.
			#1;
		end
		$display("errors %0d, checks %0d, timeout %0d", errors, checks, timedOut);
		if (errors == 0 && !timedOut) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* verification/program.hex */
// one 32-bit instruction word per line from address 0, then its assembly.
20010005 // addi r1, r0, 5
2002FFFD // addi r2, r0, -3
00221820 // add r3, r1, r2
00222022 // sub r4, r1, r2
00222824 // and r5, r1, r2
00223025 // or r6, r1, r2
0041382A // slt r7, r2, r1
0022402A // slt r8, r1, r2
08220000 // illegal opcode
0022483F // illegal funct
00210020 // add r0, r1, r1
00034820 // add r9, r0, r3
AC260010 // sw r6, 16(r1)
8C0A0015 // lw r10, 21(r0)
11460003 // beq r10, r6, +3 taken
200B0001 // addi r11, r0, 1 skipped
200B0002 // addi r11, r0, 2 skipped
10220005 // beq r1, r2, +5 not taken
14220002 // bne r1, r2, +2 taken
200B0003 // addi r11, r0, 3 skipped
14690004 // bne r3, r9, +4 not taken
218C0001 // addi r12, r12, 1
1581FFFF // bne r12, r1, -1 loops five times
AC03FFFF // sw r3, -1(r0)
8C0D00FF // lw r13, 255(r0)
01AC7020 // add r14, r13, r12
FC000000 // hlt
200F0009 // addi r15, r0, 9 never reached

/* singleCycleCpu.f */
rtl/cpuPkg.sv
rtl/fetchUnit.sv
rtl/instructionDecoder.sv
rtl/registerFile.sv
rtl/executeUnit.sv
rtl/memoryWriteback.sv
rtl/processor.sv
verification/isaRefModel.sv
verification/processorTb.sv

/* Makefile */
# Verilator build and run of the single-cycle cpu testbench.
VERILATOR ?= verilator
TOP ?= processorTb
FILELIST ?= singleCycleCpu.f
BUILDDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILDDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILDDIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
